// ==== lsu_cfg.svh ====
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// datapath widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32
`define LSU_STRB_W 4
`define LSU_ID_W 4
`define LSU_REG_W 5

// axi transfer size codes
`define LSU_SIZE_BYTE 3'd0
`define LSU_SIZE_HALF 3'd1
`define LSU_SIZE_WORD 3'd2

// axi response code
`define LSU_RESP_OKAY 2'b00

// axi burst type, single beat only
`define LSU_BURST_INCR 2'b01

`endif

// ==== lsu_pkg.sv ====
`include "lsu_cfg.svh"

package lsu_pkg;

    typedef logic [`LSU_ADDR_W-1:0] addr_t;       // byte address
    typedef logic [`LSU_DATA_W-1:0] data_t;
    typedef logic [`LSU_STRB_W-1:0] strb_t;       // one bit per byte lane
    typedef logic [2:0] size_t;                   // axi size code
    typedef logic [`LSU_ID_W-1:0] axi_id_t;
    typedef logic [1:0] axi_resp_t;
    typedef logic [`LSU_REG_W-1:0] reg_idx_t;     // destination register

    // control sequence for one request
    typedef enum logic [2:0] {
        IDLE,
        DISPATCH,       // latched fields valid, pick a path
        WRITE_ADDR,
        WRITE_DATA,
        WRITE_RESP,
        READ_ADDR,
        READ_DATA,
        WB_WAIT         // result held for write-back
    } lsu_state_e;

endpackage

// ==== lsu_req_latch.sv ====
`timescale 1ns/1ps

module lsu_req_latch (
    input  logic              clock,
    input  logic              reset,
    input  logic              accept,
    input  lsu_pkg::addr_t    mem_addr,
    input  lsu_pkg::data_t    mem_wdata,
    input  logic              mem_wen,
    input  lsu_pkg::size_t    mem_size,
    input  logic              mem_unsigned,
    input  logic              mem_use_lsu,
    input  lsu_pkg::reg_idx_t mem_rd,
    input  logic              mem_rd_wen,
    output lsu_pkg::addr_t    saved_addr,
    output lsu_pkg::data_t    saved_wdata,
    output logic              saved_wen,
    output lsu_pkg::size_t    saved_size,
    output logic              saved_unsigned,
    output logic              saved_use_lsu,
    output lsu_pkg::reg_idx_t saved_rd,
    output logic              saved_rd_wen,
    output lsu_pkg::axi_id_t  cur_id
);

    // request fields, only written on accept
    always_ff @(posedge clock) begin
        if (accept) begin
            saved_addr     <= mem_addr;
            saved_wdata    <= mem_wdata;
            saved_wen      <= mem_wen;
            saved_size     <= mem_size;
            saved_unsigned <= mem_unsigned;
            saved_use_lsu  <= mem_use_lsu;
            saved_rd       <= mem_rd;
            saved_rd_wen   <= mem_rd_wen;
        end
    end

    // one id per accepted request, wraps at the id width
    always_ff @(posedge clock) begin
        if (reset) begin
            cur_id <= '0;
        end else if (accept) begin
            cur_id <= cur_id + 1'b1;    // first request gets id 1
        end
    end

endmodule

// ==== lsu_store_align.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_store_align (
    input  lsu_pkg::addr_t saved_addr,
    input  lsu_pkg::size_t saved_size,
    input  lsu_pkg::data_t saved_wdata,
    output lsu_pkg::data_t wdata,
    output lsu_pkg::strb_t wstrb
);

    logic [1:0] offset;
    logic [4:0] lane_shift;     // bit offset of the target lane

    assign offset     = saved_addr[1:0];
    assign lane_shift = {offset, 3'b000};

    always_comb begin
        // misaligned or unknown size: no lanes written, data as given
        wdata = saved_wdata;
        wstrb = '0;
        case (saved_size)
            `LSU_SIZE_BYTE: begin
                wdata = lsu_pkg::data_t'(saved_wdata[7:0]) << lane_shift;
                wstrb = lsu_pkg::strb_t'(1) << offset;
            end
            `LSU_SIZE_HALF: begin
                if (offset == 2'd0) begin
                    wdata = {16'h0000, saved_wdata[15:0]};
                    wstrb = 4'b0011;
                end else if (offset == 2'd2) begin
                    wdata = {saved_wdata[15:0], 16'h0000};     // upper half
                    wstrb = 4'b1100;
                end
            end
            `LSU_SIZE_WORD: begin
                if (offset == 2'd0) begin
                    wstrb = 4'b1111;
                end
            end
            default: begin
                wstrb = '0;
            end
        endcase
    end

endmodule

// ==== lsu_load_result.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_load_result (
    input  logic           clock,
    input  logic           reset,
    input  logic           accept,
    input  logic           load_capture,
    input  lsu_pkg::data_t mem_result,
    input  lsu_pkg::data_t rdata,
    input  lsu_pkg::addr_t saved_addr,
    input  lsu_pkg::size_t saved_size,
    input  logic           saved_unsigned,
    output lsu_pkg::data_t result
);

    logic [1:0]     offset;
    lsu_pkg::data_t lane_data;      // addressed lane moved down to bit 0
    logic [7:0]     ld_byte;
    logic [15:0]    ld_half;
    lsu_pkg::data_t load_value;

    assign offset    = saved_addr[1:0];
    assign lane_data = rdata >> {offset, 3'b000};
    assign ld_byte   = lane_data[7:0];
    assign ld_half   = lane_data[15:0];

    always_comb begin
        load_value = '0;    // misaligned and unknown sizes read as zero
        case (saved_size)
            `LSU_SIZE_BYTE: begin
                if (saved_unsigned) begin
                    load_value = {24'h000000, ld_byte};
                end else begin
                    load_value = {{24{ld_byte[7]}}, ld_byte};
                end
            end
            `LSU_SIZE_HALF: begin
                if (offset == 2'd0 || offset == 2'd2) begin
                    if (saved_unsigned) begin
                        load_value = {16'h0000, ld_half};
                    end else begin
                        load_value = {{16{ld_half[15]}}, ld_half};
                    end
                end
            end
            `LSU_SIZE_WORD: begin
                if (offset == 2'd0) begin
                    load_value = rdata;
                end
            end
            default: begin
                load_value = '0;
            end
        endcase
    end

    // execute result first, overwritten by the load data on a good response
    always_ff @(posedge clock) begin
        if (reset) begin
            result <= '0;
        end else if (accept) begin
            result <= mem_result;
        end else if (load_capture) begin
            result <= load_value;
        end
    end

endmodule

// ==== lsu_ctrl.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_ctrl (
    input  logic               clock,
    input  logic               reset,
    input  logic               mem_valid,
    input  logic               saved_wen,
    input  logic               saved_use_lsu,
    input  logic               awready,
    input  logic               wready,
    input  logic               bvalid,
    input  lsu_pkg::axi_resp_t bresp,
    input  logic               arready,
    input  logic               rvalid,
    input  lsu_pkg::axi_resp_t rresp,
    input  logic               wbu_ready,
    output logic               mem_ready,
    output logic               accept,
    output logic               load_capture,
    output logic               awvalid,
    output logic               wvalid,
    output logic               bready,
    output logic               arvalid,
    output logic               rready,
    output logic               wbu_valid
);

    lsu_pkg::lsu_state_e state;
    lsu_pkg::lsu_state_e next_state;
    logic                bresp_ok;
    logic                rresp_ok;

    assign bresp_ok = (bresp == `LSU_RESP_OKAY);
    assign rresp_ok = (rresp == `LSU_RESP_OKAY);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= lsu_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            lsu_pkg::IDLE: begin
                if (mem_valid) begin
                    next_state = lsu_pkg::DISPATCH;
                end
            end
            lsu_pkg::DISPATCH: begin
                // latch holds the request by now
                if (!saved_use_lsu) begin
                    next_state = lsu_pkg::WB_WAIT;
                end else if (saved_wen) begin
                    next_state = lsu_pkg::WRITE_ADDR;
                end else begin
                    next_state = lsu_pkg::READ_ADDR;
                end
            end
            lsu_pkg::WRITE_ADDR: begin
                if (awready) begin
                    next_state = lsu_pkg::WRITE_DATA;
                end
            end
            lsu_pkg::WRITE_DATA: begin
                if (wready) begin
                    next_state = lsu_pkg::WRITE_RESP;
                end
            end
            lsu_pkg::WRITE_RESP: begin
                if (bvalid) begin
                    // failed store is dropped, never reaches write-back
                    next_state = bresp_ok ? lsu_pkg::WB_WAIT : lsu_pkg::IDLE;
                end
            end
            lsu_pkg::READ_ADDR: begin
                if (arready) begin
                    next_state = lsu_pkg::READ_DATA;
                end
            end
            lsu_pkg::READ_DATA: begin
                if (rvalid) begin
                    next_state = rresp_ok ? lsu_pkg::WB_WAIT : lsu_pkg::IDLE;
                end
            end
            lsu_pkg::WB_WAIT: begin
                if (wbu_ready) begin
                    next_state = lsu_pkg::IDLE;
                end
            end
            default: begin
                next_state = lsu_pkg::IDLE;
            end
        endcase
    end

    // handshake outputs are pure state decodes
    assign mem_ready = (state == lsu_pkg::IDLE);
    assign awvalid   = (state == lsu_pkg::WRITE_ADDR);
    assign wvalid    = (state == lsu_pkg::WRITE_DATA);
    assign bready    = (state == lsu_pkg::WRITE_RESP);
    assign arvalid   = (state == lsu_pkg::READ_ADDR);
    assign rready    = (state == lsu_pkg::READ_DATA);
    assign wbu_valid = (state == lsu_pkg::WB_WAIT);

    assign accept       = mem_ready && mem_valid;          // single cycle, in IDLE only
    assign load_capture = rready && rvalid && rresp_ok;

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_top (
    input  logic               clock,
    input  logic               reset,
    input  logic               mem_valid,
    output logic               mem_ready,
    input  lsu_pkg::addr_t     mem_addr,
    input  lsu_pkg::data_t     mem_wdata,
    input  logic               mem_wen,
    input  lsu_pkg::size_t     mem_size,
    input  logic               mem_unsigned,
    input  logic               mem_use_lsu,
    input  lsu_pkg::reg_idx_t  mem_rd,
    input  logic               mem_rd_wen,
    input  lsu_pkg::data_t     mem_result,
    output logic               wbu_valid,
    input  logic               wbu_ready,
    output lsu_pkg::reg_idx_t  wbu_rd,
    output logic               wbu_rd_wen,
    output lsu_pkg::data_t     wbu_data,
    output logic               awvalid,
    input  logic               awready,
    output lsu_pkg::addr_t     awaddr,
    output lsu_pkg::axi_id_t   awid,
    output logic [7:0]         awlen,
    output lsu_pkg::size_t     awsize,
    output logic [1:0]         awburst,
    output logic               wvalid,
    input  logic               wready,
    output lsu_pkg::data_t     wdata,
    output lsu_pkg::strb_t     wstrb,
    output logic               wlast,
    input  logic               bvalid,
    output logic               bready,
    input  lsu_pkg::axi_resp_t bresp,
    input  lsu_pkg::axi_id_t   bid,
    output logic               arvalid,
    input  logic               arready,
    output lsu_pkg::addr_t     araddr,
    output lsu_pkg::axi_id_t   arid,
    output logic [7:0]         arlen,
    output lsu_pkg::size_t     arsize,
    output logic [1:0]         arburst,
    input  logic               rvalid,
    output logic               rready,
    input  lsu_pkg::data_t     rdata,
    input  lsu_pkg::axi_resp_t rresp,
    input  lsu_pkg::axi_id_t   rid
);

    logic              accept;
    logic              load_capture;
    lsu_pkg::addr_t    saved_addr;
    lsu_pkg::data_t    saved_wdata;
    logic              saved_wen;
    lsu_pkg::size_t    saved_size;
    logic              saved_unsigned;
    logic              saved_use_lsu;
    lsu_pkg::axi_id_t  cur_id;

    // single beat bursts, bid and rid are not checked
    assign awlen   = 8'd0;
    assign arlen   = 8'd0;
    assign awburst = `LSU_BURST_INCR;
    assign arburst = `LSU_BURST_INCR;
    assign wlast   = 1'b1;

    assign awaddr = saved_addr;
    assign araddr = saved_addr;
    assign awsize = saved_size;
    assign arsize = saved_size;
    assign awid   = cur_id;
    assign arid   = cur_id;

    lsu_ctrl u_lsu_ctrl (
        .clock(clock), .reset(reset),
        .mem_valid(mem_valid), .saved_wen(saved_wen), .saved_use_lsu(saved_use_lsu),
        .awready(awready), .wready(wready), .bvalid(bvalid), .bresp(bresp),
        .arready(arready), .rvalid(rvalid), .rresp(rresp), .wbu_ready(wbu_ready),
        .mem_ready(mem_ready), .accept(accept), .load_capture(load_capture),
        .awvalid(awvalid), .wvalid(wvalid), .bready(bready),
        .arvalid(arvalid), .rready(rready), .wbu_valid(wbu_valid)
    );

    lsu_req_latch u_lsu_req_latch (
        .clock(clock), .reset(reset), .accept(accept),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wen(mem_wen),
        .mem_size(mem_size), .mem_unsigned(mem_unsigned), .mem_use_lsu(mem_use_lsu),
        .mem_rd(mem_rd), .mem_rd_wen(mem_rd_wen),
        .saved_addr(saved_addr), .saved_wdata(saved_wdata), .saved_wen(saved_wen),
        .saved_size(saved_size), .saved_unsigned(saved_unsigned),
        .saved_use_lsu(saved_use_lsu), .saved_rd(wbu_rd), .saved_rd_wen(wbu_rd_wen),
        .cur_id(cur_id)
    );

    lsu_store_align u_lsu_store_align (
        .saved_addr(saved_addr), .saved_size(saved_size), .saved_wdata(saved_wdata),
        .wdata(wdata), .wstrb(wstrb)
    );

    lsu_load_result u_lsu_load_result (
        .clock(clock), .reset(reset), .accept(accept), .load_capture(load_capture),
        .mem_result(mem_result), .rdata(rdata),
        .saved_addr(saved_addr), .saved_size(saved_size), .saved_unsigned(saved_unsigned),
        .result(wbu_data)
    );

endmodule

// ==== tb_axi_slave.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_axi_slave (
    input  logic               clock,
    input  logic               reset,
    input  int                 stall,       // wait cycles before each ready or valid
    input  lsu_pkg::addr_t     err_addr,    // answered with SLVERR, never written
    input  logic               awvalid,
    output logic               awready,
    input  lsu_pkg::addr_t     awaddr,
    input  lsu_pkg::axi_id_t   awid,
    input  logic               wvalid,
    output logic               wready,
    input  lsu_pkg::data_t     wdata,
    input  lsu_pkg::strb_t     wstrb,
    output logic               bvalid,
    input  logic               bready,
    output lsu_pkg::axi_resp_t bresp,
    output lsu_pkg::axi_id_t   bid,
    input  logic               arvalid,
    output logic               arready,
    input  lsu_pkg::addr_t     araddr,
    input  lsu_pkg::axi_id_t   arid,
    output logic               rvalid,
    input  logic               rready,
    output lsu_pkg::data_t     rdata,
    output lsu_pkg::axi_resp_t rresp,
    output lsu_pkg::axi_id_t   rid
);

    lsu_pkg::data_t   mem [0:255];     // word memory, address bits 9:2
    lsu_pkg::addr_t   wr_addr;
    lsu_pkg::addr_t   rd_addr;
    lsu_pkg::axi_id_t wr_id;
    lsu_pkg::axi_id_t rd_id;
    logic             b_pend;
    logic             r_pend;
    logic             go;
    logic             active;
    logic             fire;
    int               wait_cnt;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
        end
    end

    // one channel is busy at a time, so a single wait counter covers all of them
    assign go      = (wait_cnt >= stall);
    assign awready = awvalid && go;
    assign wready  = wvalid && go;
    assign arready = arvalid && go;
    assign bvalid  = b_pend && go;
    assign rvalid  = r_pend && go;
    assign bresp   = (wr_addr == err_addr) ? 2'b10 : `LSU_RESP_OKAY;
    assign rresp   = (rd_addr == err_addr) ? 2'b10 : `LSU_RESP_OKAY;
    assign rdata   = mem[rd_addr[9:2]];
    assign bid     = wr_id;
    assign rid     = rd_id;

    assign active = awvalid || wvalid || arvalid || b_pend || r_pend;
    assign fire   = awready || wready || arready || (bvalid && bready) || (rvalid && rready);

    always @(posedge clock) begin
        if (reset) begin
            wait_cnt <= 0;
            b_pend   <= 1'b0;
            r_pend   <= 1'b0;
        end else begin
            wait_cnt <= (fire || !active) ? 0 : wait_cnt + 1;
            if (awready) begin
                wr_addr <= awaddr;
                wr_id   <= awid;
            end
            if (wready) begin
                b_pend <= 1'b1;
                for (int i = 0; i < 4; i++) begin
                    if (wstrb[i] && wr_addr != err_addr) begin
                        mem[wr_addr[9:2]][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end
            if (bvalid && bready) begin
                b_pend <= 1'b0;
            end
            if (arready) begin
                rd_addr <= araddr;
                rd_id   <= arid;
                r_pend  <= 1'b1;
            end
            if (rvalid && rready) begin
                r_pend <= 1'b0;
            end
        end
    end

endmodule

// ==== tb_lsu.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_lsu;

    logic clock, reset, mem_valid, mem_ready, mem_wen, mem_unsigned, mem_use_lsu, mem_rd_wen;
    lsu_pkg::addr_t mem_addr, awaddr, araddr, err_addr;
    lsu_pkg::data_t mem_wdata, mem_result, wbu_data, wdata, rdata;
    lsu_pkg::size_t mem_size, awsize, arsize;
    lsu_pkg::reg_idx_t mem_rd, wbu_rd;
    logic wbu_valid, wbu_ready, wbu_rd_wen, awvalid, awready, wvalid, wready, wlast;
    logic bvalid, bready, arvalid, arready, rvalid, rready;
    logic [7:0] awlen, arlen;
    logic [1:0] awburst, arburst;
    lsu_pkg::strb_t wstrb;
    lsu_pkg::axi_resp_t bresp, rresp;
    lsu_pkg::axi_id_t awid, arid, bid, rid;
    lsu_pkg::axi_id_t exp_id;
    int stall;
    int cycles = 0;
    integer seed = 32'hfaed;
    // results of the last request
    logic got_wb;
    lsu_pkg::data_t got_data, got_wdata, got_addr;
    lsu_pkg::strb_t got_wstrb;
    // handshake hold monitor
    logic aw_hold, w_hold, ar_hold;
    lsu_pkg::addr_t aw_prev;
    lsu_pkg::addr_t ar_prev;
    lsu_pkg::data_t w_prev;
    lsu_pkg::strb_t ws_prev;

    lsu_top u_lsu_top (.*);
    tb_axi_slave u_slave (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= 2000) begin
            $display("Testbench failed");
            $fatal(1, "timeout: the run did not finish within 2000 clock cycles");
        end
    end

    task automatic report_error(input string name, input string exp, input string act);
        $display("ERROR at %0t: %s expected %s got %s", $time, name, exp, act);
        $display("Testbench failed");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic compare_data(input string name, input lsu_pkg::data_t exp, act);
        if (exp !== act) report_error(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic compare_strb(input string name, input lsu_pkg::strb_t exp, act);
        if (exp !== act) report_error(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic compare_id(input string name, input lsu_pkg::axi_id_t exp, act);
        if (exp !== act) report_error(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic compare_bit(input string name, input logic exp, act);
        if (exp !== act) report_error(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic compare_size(input string name, input lsu_pkg::size_t exp, act);
        if (exp !== act) report_error(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic compare_reg(input string name, input lsu_pkg::reg_idx_t exp, act);
        if (exp !== act) report_error(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic compare_len(input string name, input logic [7:0] exp, act);
        if (exp !== act) report_error(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic compare_burst(input string name, input logic [1:0] exp, act);
        if (exp !== act) report_error(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    // valid and payload must stay put while ready is low
    always @(posedge clock) begin
        aw_hold <= awvalid && !awready;
        aw_prev <= awaddr;
        w_hold  <= wvalid && !wready;
        w_prev  <= wdata;
        ws_prev <= wstrb;
        ar_hold <= arvalid && !arready;
        ar_prev <= araddr;
    end

    always @(negedge clock) begin
        if (!reset && aw_hold) begin
            compare_bit("awvalid", 1'b1, awvalid);
            compare_data("awaddr", aw_prev, awaddr);
        end
        if (!reset && w_hold) begin
            compare_bit("wvalid", 1'b1, wvalid);
            compare_data("wdata", w_prev, wdata);
            compare_strb("wstrb", ws_prev, wstrb);
        end
        if (!reset && ar_hold) begin
            compare_bit("arvalid", 1'b1, arvalid);
            compare_data("araddr", ar_prev, araddr);
        end
    end

    function automatic lsu_pkg::strb_t exp_strb(input lsu_pkg::addr_t a, input lsu_pkg::size_t s);
        case (s)
            `LSU_SIZE_BYTE: return 4'b0001 << a[1:0];
            `LSU_SIZE_HALF:
                return (a[1:0] == 2'd0) ? 4'b0011 : (a[1:0] == 2'd2) ? 4'b1100 : 4'b0000;
            `LSU_SIZE_WORD: return (a[1:0] == 2'd0) ? 4'b1111 : 4'b0000;
            default: return 4'b0000;
        endcase
    endfunction

    // replicate the store data into every lane, then blank lanes off the strobe
    function automatic lsu_pkg::data_t exp_wdata(input lsu_pkg::addr_t a,
                                                 input lsu_pkg::size_t s,
                                                 input lsu_pkg::data_t d);
        lsu_pkg::strb_t st;
        lsu_pkg::data_t v;
        st = exp_strb(a, s);
        if (st == 4'b0000) return d;
        v = (s == `LSU_SIZE_BYTE) ? {4{d[7:0]}} : (s == `LSU_SIZE_HALF) ? {2{d[15:0]}} : d;
        for (int i = 0; i < 4; i++) begin
            if (!st[i]) v[8*i +: 8] = 8'h00;
        end
        return v;
    endfunction

    function automatic lsu_pkg::data_t exp_load(input lsu_pkg::data_t w, input lsu_pkg::addr_t a,
                                                input lsu_pkg::size_t s, input logic uns);
        logic [7:0] b;
        logic [15:0] h;
        b = w[8*a[1:0] +: 8];
        h = w[16*a[1] +: 16];
        if (s == `LSU_SIZE_BYTE) return uns ? {24'h0, b} : {{24{b[7]}}, b};
        if (s == `LSU_SIZE_HALF && !a[0]) return uns ? {16'h0, h} : {{16{h[15]}}, h};
        if (s == `LSU_SIZE_WORD && a[1:0] == 2'd0) return w;
        return '0;
    endfunction

    // one request from acceptance to write-back or drop, starts and ends on a falling edge
    task automatic run_req(input logic wen, use_lsu, input lsu_pkg::addr_t a,
                           input lsu_pkg::data_t d, input lsu_pkg::size_t s,
                           input logic uns, input int wb_delay);
        lsu_pkg::reg_idx_t rd;
        logic rd_wen;
        logic drop;
        rd = lsu_pkg::reg_idx_t'($random(seed));
        rd_wen = rd[0];
        while (!mem_ready) @(negedge clock);
        mem_valid = 1'b1;
        mem_wen = wen;
        mem_use_lsu = use_lsu;
        mem_addr = a;
        mem_wdata = d;
        mem_size = s;
        mem_unsigned = uns;
        mem_rd = rd;
        mem_rd_wen = rd_wen;
        mem_result = $random(seed);
        @(negedge clock);
        mem_valid = 1'b0;
        exp_id++;
        got_wb = 1'b0;
        if (!use_lsu) begin
            compare_bit("wbu_valid", 1'b0, wbu_valid);      // still in dispatch
            @(negedge clock);
            compare_bit("wbu_valid", 1'b1, wbu_valid);
        end
        while (!wbu_valid && !mem_ready) begin
            if (awvalid) begin
                got_addr = awaddr;
                compare_id("awid", exp_id, awid);
                compare_len("awlen", 8'd0, awlen);
                compare_size("awsize", s, awsize);
                compare_burst("awburst", `LSU_BURST_INCR, awburst);
            end
            if (wvalid) begin
                got_wdata = wdata;
                got_wstrb = wstrb;
                compare_bit("wlast", 1'b1, wlast);
            end
            if (arvalid) begin
                got_addr = araddr;
                compare_id("arid", exp_id, arid);
                compare_len("arlen", 8'd0, arlen);
                compare_size("arsize", s, arsize);
                compare_burst("arburst", `LSU_BURST_INCR, arburst);
            end
            // refused response drops the request, idle one cycle later
            drop = (bready && bvalid && bresp != `LSU_RESP_OKAY)
                || (rready && rvalid && rresp != `LSU_RESP_OKAY);
            @(negedge clock);
            if (drop) begin
                compare_bit("mem_ready", 1'b1, mem_ready);
                compare_bit("wbu_valid", 1'b0, wbu_valid);
            end
        end
        if (wbu_valid) begin
            got_wb = 1'b1;
            got_data = wbu_data;
            compare_reg("wbu_rd", rd, wbu_rd);
            compare_bit("wbu_rd_wen", rd_wen, wbu_rd_wen);
            if (!use_lsu || wen) compare_data("wbu_data", mem_result, wbu_data);
            repeat (wb_delay) begin
                @(negedge clock);
                compare_bit("wbu_valid", 1'b1, wbu_valid);
                compare_data("wbu_data", got_data, wbu_data);
                compare_reg("wbu_rd", rd, wbu_rd);
                compare_bit("wbu_rd_wen", rd_wen, wbu_rd_wen);
                compare_bit("mem_ready", 1'b0, mem_ready);
            end
            wbu_ready = 1'b1;
            @(negedge clock);
            wbu_ready = 1'b0;
            compare_bit("mem_ready", 1'b1, mem_ready);
        end
    endtask

    task automatic test_passthrough();
        compare_bit("mem_ready", 1'b1, mem_ready);
        compare_bit("wbu_valid", 1'b0, wbu_valid);
        compare_bit("awvalid", 1'b0, awvalid);
        compare_bit("arvalid", 1'b0, arvalid);
        compare_bit("wvalid", 1'b0, wvalid);
        compare_bit("bready", 1'b0, bready);
        compare_bit("rready", 1'b0, rready);
        run_req(1'b0, 1'b0, $random(seed), $random(seed), `LSU_SIZE_WORD, 1'b0, 3);
        compare_bit("write-back seen", 1'b1, got_wb);
    endtask

    task automatic test_stores();
        lsu_pkg::addr_t a;
        lsu_pkg::data_t d, old, wd;
        lsu_pkg::strb_t st;
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 4; off++) begin
                a = 32'h100 + s * 16 + off;
                d = $random(seed);
                st = exp_strb(a, lsu_pkg::size_t'(s));
                wd = exp_wdata(a, lsu_pkg::size_t'(s), d);
                old = u_slave.mem[a[9:2]];
                run_req(1'b1, 1'b1, a, d, lsu_pkg::size_t'(s), 1'b0, 0);
                compare_bit("write-back seen", 1'b1, got_wb);
                compare_data("awaddr", a, got_addr);
                compare_strb("wstrb", st, got_wstrb);
                compare_data("wdata", wd, got_wdata);
                for (int i = 0; i < 4; i++) begin
                    if (st[i]) old[8*i +: 8] = wd[8*i +: 8];
                end
                compare_data("slave memory", old, u_slave.mem[a[9:2]]);
            end
        end
    endtask

    // word store, then a load of the given size at offset off
    task automatic store_then_load(input lsu_pkg::addr_t base, input int s, off, input logic uns);
        lsu_pkg::data_t w;
        w = $random(seed);
        run_req(1'b1, 1'b1, base, w, `LSU_SIZE_WORD, 1'b0, 0);
        run_req(1'b0, 1'b1, base + off, 32'h0, lsu_pkg::size_t'(s), uns, 0);
        compare_bit("write-back seen", 1'b1, got_wb);
        compare_data("wbu_data", exp_load(w, base + off, lsu_pkg::size_t'(s), uns), got_data);
    endtask

    task automatic test_loads();
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 4; off++) begin
                store_then_load(32'h200, s, off, 1'b0);
                store_then_load(32'h200, s, off, 1'b1);
            end
        end
    endtask

    task automatic test_stalls();
        for (int k = 0; k <= 5; k++) begin
            stall = k;
            store_then_load(32'h280, k % 3, (k % 3 == 0) ? k % 4 : 0, k[0]);
        end
        stall = 0;
    endtask

    task automatic test_ids_and_error();
        lsu_pkg::data_t d;
        lsu_pkg::data_t last;
        last = '0;
        for (int n = 0; n < 17; n++) begin
            d = $random(seed);
            run_req(n[0], 1'b1, 32'h300, d, `LSU_SIZE_WORD, 1'b0, 0);
            compare_bit("write-back seen", 1'b1, got_wb);
            if (n[0]) begin
                last = d;
            end else if (n > 0) begin
                compare_data("wbu_data", last, got_data);   // word stored just before
            end
        end
        err_addr = 32'h340;
        run_req(1'b1, 1'b1, 32'h340, $random(seed), `LSU_SIZE_WORD, 1'b0, 0);
        compare_bit("write-back after error", 1'b0, got_wb);
        run_req(1'b0, 1'b1, 32'h340, 32'h0, `LSU_SIZE_WORD, 1'b0, 0);
        compare_bit("write-back after error", 1'b0, got_wb);
        run_req(1'b0, 1'b1, 32'h300, 32'h0, `LSU_SIZE_WORD, 1'b0, 0);
        compare_bit("write-back seen", 1'b1, got_wb);
        compare_data("wbu_data", last, got_data);
    endtask

    initial begin
        mem_valid = 1'b0;
        mem_wen = 1'b0;
        mem_unsigned = 1'b0;
        mem_use_lsu = 1'b0;
        mem_rd_wen = 1'b0;
        wbu_ready = 1'b0;
        mem_addr = '0;
        mem_wdata = '0;
        mem_result = '0;
        mem_size = '0;
        mem_rd = '0;
        stall = 0;
        err_addr = 32'hffff_fff0;     // outside the test window
        exp_id = '0;
        reset = 1'b1;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        test_passthrough();
        test_stores();
        test_loads();
        test_stalls();
        test_ids_and_error();
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
lsu_pkg.sv
lsu_req_latch.sv
lsu_store_align.sv
lsu_load_result.sv
lsu_ctrl.sv
lsu_top.sv
tb_axi_slave.sv
tb_lsu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f sim.f --top-module tb_lsu -o tb_lsu_sim

# $fatal in the testbench gives a non-zero exit status
./obj_dir/tb_lsu_sim
